// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 4;
  localparam int PC_WIDTH       = 8; // word address into imem

  typedef enum logic [3:0] {
    NOP  = 4'd0,
    ADD,
    SUB,
    AND,
    OR,
    ADDI,
    LW,
    SW,
    BEQ
  } opcode_e;

  typedef struct packed {
    opcode_e                   opcode;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] ra;
    logic [REG_ADDR_WIDTH-1:0] rb;
    logic [15:0]               unused;
  } r_instr_t;

  // sw: rd is the data register; beq: rd is the second operand, imm a word offset from pc
  typedef struct packed {
    opcode_e                   opcode;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] ra;
    logic [19:0]               imm;
  } i_instr_t;

  typedef union packed {
    r_instr_t r_view;
    i_instr_t i_view;
  } instr_t;

  typedef struct packed {
    logic                      valid;
    logic [PC_WIDTH-1:0]       pc;
    opcode_e                   opcode;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      we;
    logic [DATA_WIDTH-1:0]     op_a;
    logic [DATA_WIDTH-1:0]     op_b;
    logic [DATA_WIDTH-1:0]     imm;
    logic [DATA_WIDTH-1:0]     st_data;
  } dec_t;

  typedef struct packed {
    logic                      valid;
    logic [PC_WIDTH-1:0]       pc;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      we;
    logic                      is_load;
    logic                      is_store;
    logic [DATA_WIDTH-1:0]     result;
    logic [DATA_WIDTH-1:0]     st_data;
  } exe_t;

  typedef struct packed {
    logic                      valid;
    logic [PC_WIDTH-1:0]       pc;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      we;
    logic [DATA_WIDTH-1:0]     data;
  } wb_t;

  typedef struct packed {
    logic                      valid;
    logic [PC_WIDTH-1:0]       pc;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      wr_en;
    logic [DATA_WIDTH-1:0]     data;
  } retire_t;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [31:0]           adr; // byte address
    logic [DATA_WIDTH-1:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic                  ack;
    logic [DATA_WIDTH-1:0] dat;
  } wb_s2m_t;

endpackage

// ==== design/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         start_i,
  input  logic                         imem_we_i,
  input  logic [cpu_pkg::PC_WIDTH-1:0] imem_addr_i,
  input  cpu_pkg::instr_t              imem_data_i,
  input  logic                         hold_i,
  input  logic                         redirect_i,
  input  logic [cpu_pkg::PC_WIDTH-1:0] target_i,
  output logic                         valid_o,
  output logic [cpu_pkg::PC_WIDTH-1:0] pc_o,
  output cpu_pkg::instr_t              instr_o
);

  cpu_pkg::instr_t              imem [IMEM_DEPTH];
  logic                         run_q;
  logic [cpu_pkg::PC_WIDTH-1:0] pc_q;

  always_ff @(posedge clk_i) begin
    if (imem_we_i) begin
      imem[imem_addr_i] <= imem_data_i; // load port, used before start
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      run_q <= 1'b0;
      pc_q  <= '0;
    end else begin
      if (start_i) begin
        run_q <= 1'b1; // sticky until reset
      end
      if (run_q && !hold_i) begin
        pc_q <= redirect_i ? target_i : pc_q + cpu_pkg::PC_WIDTH'(1);
      end
    end
  end

  assign valid_o = run_q;
  assign pc_o    = pc_q;
  assign instr_o = imem[pc_q]; // asynchronous read

  // the program must be complete before the core is released
  assert property (@(posedge clk_i) disable iff (!rst_i) run_q |-> !imem_we_i)
    else $error("instruction memory written while the core runs");

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
  input  logic                               valid_i,
  input  logic [cpu_pkg::PC_WIDTH-1:0]       pc_i,
  input  cpu_pkg::instr_t                    instr_i,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs_a_o,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs_b_o,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     rd_a_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     rd_b_i,
  output cpu_pkg::dec_t                      dec_o
);

  cpu_pkg::opcode_e              op;
  logic [cpu_pkg::DATA_WIDTH-1:0] imm_ext;

  assign op      = instr_i.r_view.opcode;
  assign imm_ext = {{(cpu_pkg::DATA_WIDTH - $bits(instr_i.i_view.imm)){instr_i.i_view.imm[19]}},
                    instr_i.i_view.imm};

  // sw and beq read their second register from the rd field
  assign rs_a_o = instr_i.r_view.ra;
  assign rs_b_o = (op == cpu_pkg::SW || op == cpu_pkg::BEQ) ? instr_i.i_view.rd
                                                            : instr_i.r_view.rb;

  always_comb begin
    dec_o         = '0;
    dec_o.valid   = valid_i;
    dec_o.pc      = pc_i;
    dec_o.rd      = instr_i.r_view.rd;
    dec_o.op_a    = rd_a_i;
    dec_o.op_b    = rd_b_i;
    dec_o.imm     = imm_ext;
    dec_o.st_data = rd_b_i;
    dec_o.opcode  = cpu_pkg::NOP; // squashed slots decode as nop
    if (valid_i) begin
      dec_o.opcode = op;
      case (op)
        cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR: dec_o.we = 1'b1;
        cpu_pkg::ADDI, cpu_pkg::LW: begin
          dec_o.we   = 1'b1;
          dec_o.op_b = imm_ext;
        end
        cpu_pkg::SW:  dec_o.op_b = imm_ext; // address = ra + imm
        cpu_pkg::BEQ: dec_o.op_b = rd_b_i;
        cpu_pkg::NOP: dec_o.op_b = '0;
        default:      dec_o.opcode = cpu_pkg::NOP; // unknown opcode
      endcase
    end
  end

endmodule

// ==== design/rbank.sv ====
`timescale 1ns/100ps

module rbank (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               wr_en_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wr_reg_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     wr_data_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rd_reg_a_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rd_reg_b_i,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     reg_a_data_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     reg_b_data_o
);

  localparam int NUM_REGS = 2 ** cpu_pkg::REG_ADDR_WIDTH;

  logic [cpu_pkg::DATA_WIDTH-1:0] regs_q [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_reg_i != '0)) begin
      regs_q[wr_reg_i] <= wr_data_i; // r0 stays zero
    end
  end

  // no write-through, a write is visible from the next cycle
  assign reg_a_data_o = regs_q[rd_reg_a_i];
  assign reg_b_data_o = regs_q[rd_reg_b_i];

endmodule

// ==== design/alu_stage.sv ====
`timescale 1ns/100ps

module alu_stage (
  input  cpu_pkg::dec_t                dec_i,
  output cpu_pkg::exe_t                exe_o,
  output logic                         branch_taken_o,
  output logic [cpu_pkg::PC_WIDTH-1:0] branch_target_o
);

  logic is_beq;

  assign is_beq = dec_i.valid && (dec_i.opcode == cpu_pkg::BEQ);

  always_comb begin
    exe_o.valid    = dec_i.valid;
    exe_o.pc       = dec_i.pc;
    exe_o.rd       = dec_i.rd;
    exe_o.we       = dec_i.we;
    exe_o.is_load  = dec_i.valid && (dec_i.opcode == cpu_pkg::LW);
    exe_o.is_store = dec_i.valid && (dec_i.opcode == cpu_pkg::SW);
    exe_o.st_data  = dec_i.st_data;
    case (dec_i.opcode)
      cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::LW, cpu_pkg::SW: begin
        exe_o.result = dec_i.op_a + dec_i.op_b; // byte address for lw and sw
      end
      cpu_pkg::SUB: begin
        exe_o.result = dec_i.op_a - dec_i.op_b;
      end
      cpu_pkg::AND: begin
        exe_o.result = dec_i.op_a & dec_i.op_b;
      end
      cpu_pkg::OR: begin
        exe_o.result = dec_i.op_a | dec_i.op_b;
      end
      default: begin
        exe_o.result = '0; // nop, beq
      end
    endcase
  end

  assign branch_taken_o  = is_beq && (dec_i.op_a == dec_i.op_b);
  assign branch_target_o = dec_i.pc + dec_i.imm[cpu_pkg::PC_WIDTH-1:0]; // word offset

endmodule

// ==== design/mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cpu_pkg::exe_t     exe_i,
  output cpu_pkg::wb_m2s_t  wb_o,
  input  cpu_pkg::wb_s2m_t  wb_i,
  output logic              stall_o,
  output cpu_pkg::wb_t      wbk_o
);

  logic busy_q; // bus cycle in flight
  logic mem_op;

  assign mem_op = exe_i.valid && (exe_i.is_load || exe_i.is_store);

  // two states: idle, then busy from request until ack
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      busy_q <= 1'b0;
    end else if (!busy_q) begin
      busy_q <= mem_op;
    end else if (wb_i.ack) begin
      busy_q <= 1'b0; // cyc and stb drop the cycle after ack
    end
  end

  // address and data come straight from the execute register,
  // which the stall keeps frozen for the whole transfer
  always_comb begin
    wb_o.cyc = busy_q;
    wb_o.stb = busy_q;
    wb_o.we  = exe_i.is_store;
    wb_o.adr = exe_i.result;
    wb_o.dat = exe_i.st_data;
  end

  assign stall_o = mem_op && !(busy_q && wb_i.ack);

  // load data is taken in the ack cycle by the writeback register
  always_comb begin
    wbk_o.valid = exe_i.valid;
    wbk_o.pc    = exe_i.pc;
    wbk_o.rd    = exe_i.rd;
    wbk_o.we    = exe_i.we;
    wbk_o.data  = exe_i.is_load ? wb_i.dat : exe_i.result;
  end

  // relies on cpu holding the execute register while stalled
  assert property (@(posedge clk_i) disable iff (!rst_i)
    (wb_o.stb && !wb_i.ack) |=>
      (wb_o.stb && $stable({wb_o.we, wb_o.adr, wb_o.dat})))
    else $error("wishbone request changed before ack");

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/100ps

module cpu #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         start_i,
  input  logic                         imem_we_i,
  input  logic [cpu_pkg::PC_WIDTH-1:0] imem_addr_i,
  input  cpu_pkg::instr_t              imem_data_i,
  output cpu_pkg::wb_m2s_t             wb_o,
  input  cpu_pkg::wb_s2m_t             wb_i,
  output cpu_pkg::retire_t             retire_o
);

  logic                               stall;
  logic                               flush; // taken beq in execute
  logic [cpu_pkg::PC_WIDTH-1:0]       branch_target;
  logic                               f_valid;
  logic [cpu_pkg::PC_WIDTH-1:0]       f_pc;
  cpu_pkg::instr_t                    f_instr;
  logic                               fd_valid_q;
  logic [cpu_pkg::PC_WIDTH-1:0]       fd_pc_q;
  cpu_pkg::instr_t                    fd_instr_q;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs_a;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs_b;
  logic [cpu_pkg::DATA_WIDTH-1:0]     rd_a;
  logic [cpu_pkg::DATA_WIDTH-1:0]     rd_b;
  cpu_pkg::dec_t                      dec_d;
  cpu_pkg::dec_t                      dec_q;
  cpu_pkg::exe_t                      exe_d;
  cpu_pkg::exe_t                      exe_q;
  cpu_pkg::wb_t                       wbk_d;
  cpu_pkg::wb_t                       wb_q;

  fetch_stage #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) i_fetch (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .imem_we_i   (imem_we_i),
    .imem_addr_i (imem_addr_i),
    .imem_data_i (imem_data_i),
    .hold_i      (stall),
    .redirect_i  (flush),
    .target_i    (branch_target),
    .valid_o     (f_valid),
    .pc_o        (f_pc),
    .instr_o     (f_instr)
  );

  decode_stage i_decode (
    .valid_i (fd_valid_q),
    .pc_i    (fd_pc_q),
    .instr_i (fd_instr_q),
    .rs_a_o  (rs_a),
    .rs_b_o  (rs_b),
    .rd_a_i  (rd_a),
    .rd_b_i  (rd_b),
    .dec_o   (dec_d)
  );

  rbank i_rbank (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wr_en_i      (wb_q.valid && wb_q.we),
    .wr_reg_i     (wb_q.rd),
    .wr_data_i    (wb_q.data),
    .rd_reg_a_i   (rs_a),
    .rd_reg_b_i   (rs_b),
    .reg_a_data_o (rd_a),
    .reg_b_data_o (rd_b)
  );

  alu_stage i_alu (
    .dec_i           (dec_q),
    .exe_o           (exe_d),
    .branch_taken_o  (flush),
    .branch_target_o (branch_target)
  );

  mem_stage i_mem (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .exe_i   (exe_q),
    .wb_o    (wb_o),
    .wb_i    (wb_i),
    .stall_o (stall),
    .wbk_o   (wbk_d)
  );

  // payload loads first, the valid bits below override it
  always_ff @(posedge clk_i) begin
    if (!stall) begin
      fd_pc_q    <= f_pc;
      fd_instr_q <= f_instr;
      dec_q      <= dec_d;
      exe_q      <= exe_d;
    end
    wb_q <= wbk_d;
    if (!rst_i) begin
      fd_valid_q  <= 1'b0;
      dec_q.valid <= 1'b0;
      exe_q.valid <= 1'b0;
      wb_q.valid  <= 1'b0;
    end else begin
      wb_q.valid <= wbk_d.valid && !stall; // bubble while the bus waits
      if (!stall) begin
        fd_valid_q  <= f_valid && !flush;
        dec_q.valid <= dec_d.valid && !flush; // drop the two younger slots
        exe_q.valid <= exe_d.valid;
      end
    end
  end

  always_comb begin
    retire_o.valid = wb_q.valid;
    retire_o.pc    = wb_q.pc;
    retire_o.rd    = wb_q.rd;
    retire_o.wr_en = wb_q.we;
    retire_o.data  = wb_q.data;
  end

endmodule

// ==== verification/cpu_tb.sv ====
`timescale 1ns/100ps

module cpu_tb;

  localparam int IMEM_DEPTH  = 256;
  localparam int DMEM_WORDS  = 256;
  localparam int RUN_TIMEOUT = 2000; // cycles after start
  localparam int CLK_PERIOD  = 8;

  logic                         clk_i;
  logic                         rst_i;
  logic                         start;
  logic                         imem_we;
  logic [cpu_pkg::PC_WIDTH-1:0] imem_addr;
  cpu_pkg::instr_t              imem_data;
  cpu_pkg::wb_m2s_t             wb_req;
  cpu_pkg::wb_s2m_t             wb_rsp;
  cpu_pkg::retire_t             retire;

  cpu_pkg::instr_t  prog [IMEM_DEPTH]; // unlisted words stay nop
  logic [31:0]      dmem [DMEM_WORDS];
  cpu_pkg::retire_t exp_retire [$];
  cpu_pkg::wb_m2s_t exp_write [$];
  int               n_exp_retire;
  int               n_exp_write;
  int               seed;
  int               end_pc; // last program word, a trailing nop
  int               errors;
  int               tests;
  int               n_retired;
  int               n_writes;
  logic             drained;
  logic             req_pending;
  int               wait_left;
  cpu_pkg::wb_m2s_t req_seen;

  cpu #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start),
    .imem_we_i   (imem_we),
    .imem_addr_i (imem_addr),
    .imem_data_i (imem_data),
    .wb_o        (wb_req),
    .wb_i        (wb_rsp),
    .retire_o    (retire)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_retire(input string name, input cpu_pkg::retire_t exp,
                              input cpu_pkg::retire_t act);
    logic ok;
    ok = (act.pc == exp.pc) && (act.wr_en == exp.wr_en);
    if (exp.wr_en) begin
      ok = ok && (act.rd == exp.rd) && (act.data == exp.data); // rd, data only count on a write
    end
    tests++;
    if (ok) begin
      $display("[PASS] %s", name);
    end else begin
      errors++;
      $display("[ERROR] %s expected pc=%h rd=%h wr_en=%b data=%h, %s",
               name, exp.pc, exp.rd, exp.wr_en, exp.data,
               $sformatf("actual pc=%h rd=%h wr_en=%b data=%h",
                         act.pc, act.rd, act.wr_en, act.data));
    end
  endtask

  task automatic check_bus_write(input string name, input cpu_pkg::wb_m2s_t exp,
                                 input cpu_pkg::wb_m2s_t act);
    tests++;
    if (act.we == exp.we && act.adr == exp.adr && act.dat == exp.dat) begin
      $display("[PASS] %s", name);
    end else begin
      errors++;
      $display("[ERROR] %s expected we=%b adr=%h dat=%h, actual we=%b adr=%h dat=%h",
               name, exp.we, exp.adr, exp.dat, act.we, act.adr, act.dat);
    end
  endtask

  task automatic read_golden();
    int                    fd;
    int                    n;
    logic [7:0]            kind;
    logic [31:0]           a;
    logic [31:0]           d;
    logic [31:0]           rd_f;
    logic [31:0]           we_f;
    logic [8*160-1:0]      line;
    cpu_pkg::retire_t      r;
    cpu_pkg::wb_m2s_t      w;
    fd = $fopen("verification/cpu_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open verification/cpu_golden.txt");
    end else begin
      n = $fscanf(fd, " %c", kind);
      while (n == 1) begin
        case (kind)
          "#": n = $fgets(line, fd);
          "P": begin
            n = $fscanf(fd, "%h %h", a, d);
            prog[a[7:0]] = d;
            end_pc = a;
          end
          "M": begin
            n = $fscanf(fd, "%h %h", a, d);
            dmem[a[9:2]] = d; // byte address
          end
          "R": begin
            n = $fscanf(fd, "%h %h %h %h", a, rd_f, we_f, d);
            r = '0;
            r.valid = 1'b1;
            r.pc = a[7:0];
            r.rd = rd_f[3:0];
            r.wr_en = we_f[0];
            r.data = d;
            exp_retire.push_back(r);
          end
          "W": begin
            n = $fscanf(fd, "%h %h", a, d);
            w = '0;
            w.cyc = 1'b1;
            w.stb = 1'b1;
            w.we = 1'b1;
            w.adr = a;
            w.dat = d;
            exp_write.push_back(w);
          end
          default: begin
            errors++;
            $display("golden file holds an unknown record kind '%c'", kind);
          end
        endcase
        n = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);
    end
    n_exp_retire = exp_retire.size();
    n_exp_write  = exp_write.size();
  endtask

  task automatic load_program();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      @(negedge clk_i);
      imem_we   = 1'b1;
      imem_addr = cpu_pkg::PC_WIDTH'(i);
      imem_data = prog[i];
    end
    @(negedge clk_i);
    imem_we = 1'b0;
  endtask

  // wishbone classic slave, 0 to 3 wait states per transfer
  task automatic serve_bus();
    cpu_pkg::wb_m2s_t req;
    cpu_pkg::wb_m2s_t exp;
    req = wb_req;
    if (wb_rsp.ack) begin
      wb_rsp = '0;
      if (req.cyc || req.stb) begin
        errors++;
        $display("cyc or stb still high in the cycle after ack");
      end
    end else if (req.cyc && req.stb) begin
      if (!req_pending) begin
        req_pending = 1'b1;
        req_seen    = req;
        wait_left   = $random(seed) & 3;
      end else if (req != req_seen) begin
        errors++;
        $display("bus request changed while waiting for ack");
      end
      if (wait_left == 0) begin
        if (req.adr[31:10] != '0 || req.adr[1:0] != 2'b00) begin
          errors++;
          $display("bus access to %h is outside data memory or misaligned", req.adr);
        end
        if (req.we) begin
          n_writes++;
          if (exp_write.size() == 0) begin
            errors++;
            $display("unexpected bus write of %h to %h", req.dat, req.adr);
          end else begin
            exp = exp_write.pop_front();
            check_bus_write($sformatf("bus write #%0d", n_writes), exp, req);
          end
          dmem[req.adr[9:2]] = req.dat;
        end else begin
          wb_rsp.dat = dmem[req.adr[9:2]];
        end
        wb_rsp.ack  = 1'b1;
        req_pending = 1'b0;
      end else begin
        wait_left--;
      end
    end
  endtask

  task automatic watch_retire();
    cpu_pkg::retire_t act;
    cpu_pkg::retire_t exp;
    act = retire;
    if (act.valid) begin
      if (int'(act.pc) == end_pc) begin
        drained = 1'b1;
      end
      if (prog[act.pc].r_view.opcode != cpu_pkg::NOP) begin // nops are not tracked
        n_retired++;
        if (exp_retire.size() == 0) begin
          errors++;
          $display("unexpected retire at pc %h after the last expected one", act.pc);
        end else begin
          exp = exp_retire.pop_front();
          check_retire($sformatf("retire #%0d pc %h", n_retired, exp.pc), exp, act);
        end
      end
    end
  endtask

  initial begin
    int cycles;
    seed        = 32'hcf6c;
    errors      = 0;
    tests       = 0;
    n_retired   = 0;
    n_writes    = 0;
    end_pc      = 0;
    drained     = 1'b0;
    req_pending = 1'b0;
    wait_left   = 0;
    req_seen    = '0;
    rst_i       = 1'b0;
    start       = 1'b0;
    imem_we     = 1'b0;
    imem_addr   = '0;
    imem_data   = '0;
    wb_rsp      = '0;
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      prog[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'hd0d0_0000 ^ (32'(i) * 32'h0001_0021);
    end
    read_golden();
    repeat (5) @(negedge clk_i);
    rst_i = 1'b1;
    load_program();
    @(negedge clk_i);
    start = 1'b1;
    @(negedge clk_i);
    start = 1'b0;
    cycles = 0;
    while (!drained && cycles < RUN_TIMEOUT) begin
      @(negedge clk_i);
      serve_bus();
      watch_retire();
      cycles++;
    end
    if (!drained) begin
      errors++;
      $display("timeout: pc %0h did not retire within %0d cycles", end_pc, RUN_TIMEOUT);
    end
    tests++;
    if (n_retired != n_exp_retire) begin
      errors++;
      $display("[ERROR] retire count expected %0d actual %0d", n_exp_retire, n_retired);
    end else begin
      $display("[PASS] retire count %0d", n_retired);
    end
    tests++;
    if (n_writes != n_exp_write) begin
      errors++;
      $display("[ERROR] bus write count expected %0d actual %0d", n_exp_write, n_writes);
    end else begin
      $display("[PASS] bus write count %0d", n_writes);
    end
    $display("tests: %0d, errors: %0d, retires: %0d, bus writes: %0d",
             tests, errors, n_retired, n_writes);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== cpu.f ====
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/rbank.sv
design/alu_stage.sv
design/mem_stage.sv
design/cpu.sv
verification/cpu_tb.sv

// ==== Makefile ====
SRCS := $(shell cat cpu.f)
BIN  := obj_dir/Vcpu_tb

.PHONY: all run clean

all: run

$(BIN): cpu.f $(SRCS)
	verilator --binary --assert --top-module cpu_tb -f cpu.f

run: $(BIN)
	./$(BIN) | tee sim.log
	@! grep -q "Simulation finished: FAIL" sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/cpu_golden.txt ====
# P pc word | M byte_addr word | W byte_addr data (expected bus write)
# R pc rd wr_en data (expected retire, nops left out, rd and data unchecked when wr_en is 0)
P 00 5100000c
P 01 52000005
P 02 530ffffd
P 03 50000007
P 06 14120000
P 07 25120000
P 08 37120000
P 09 46230000
P 0a 18000000
P 0b 69100004
P 0c 74000020
P 0d 76100008
P 10 6a000020
P 11 82100005
P 12 1b970000
P 13 80800004
P 14 5c000111
P 15 5d000222
P 16 5e000333
P 17 5fa00001
P 1c 00000000
M 00000010 00000123
R 00 1 1 0000000c
R 01 2 1 00000005
R 02 3 1 fffffffd
R 03 0 1 00000007
R 06 4 1 00000011
R 07 5 1 00000007
R 08 7 1 00000004
R 09 6 1 fffffffd
R 0a 8 1 00000000
R 0b 9 1 00000123
R 0c 0 0 00000000
R 0d 0 0 00000000
R 10 a 1 00000011
R 11 0 0 00000000
R 12 b 1 00000127
R 13 0 0 00000000
R 17 f 1 00000012
W 00000020 00000011
W 00000014 fffffffd
